/* vlog.f */
periph_pkg.sv
periph_bus_if.sv
periph_decode.sv
read_response.sv
gpio_regs.sv
pwm_byte.sv
pin_mux.sv
periph_top.sv
periph_props.sv
tb_periph.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the output for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_periph -o sim_periph \
    || { echo "Build failed"; exit 1; }

out="$(./obj_dir/sim_periph 2>&1)"
echo "$out"

grep -qx "=== PASS ===" <<< "$out" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tb_periph.sv */
// Table-driven testbench for the peripheral block; compile with vlog.f, top module tb_periph
`timescale 1ns/1ps
`default_nettype none

module tb_periph;
    import periph_pkg::*;

    typedef enum {OP_WR, OP_RD, OP_HOLD, OP_PINS, OP_ASEL, OP_PWM} op_t;
    typedef struct {
        op_t   op;
        addr_t addr;
        data_t data;  // Pin index for OP_PWM
        pin_t  ui;    // Expected GPIO pattern on the other pins for OP_PWM
        data_t exp;
        string name;
    } step_t;

    localparam addr_t GPIO_BASE  = {USER_GPIO_SLOT, 6'h00};
    localparam addr_t PWM_BASE   = {SIMPLE_REGION, 1'b0, SIMPLE_PWM_SLOT, 4'h0};
    localparam int    READ_LIMIT = 16; // Cycles to wait for ready

    logic        clk;
    logic        rst_n;
    pin_t        ui_in;
    pin_t        uo_out;
    logic        o_audio;
    logic        o_audio_select;
    addr_t       i_addr;
    data_t       i_data_in;
    access_t     i_data_write_n;
    access_t     i_data_read_n;
    data_t       o_data_out;
    logic        o_data_ready;
    logic        i_data_read_complete;
    step_t       steps[$];
    logic [31:0] rng;
    int          limit_cycles = 0;

    periph_top periph_top_inst (
        .clk                  (clk),
        .rst_n                (rst_n),
        .ui_in                (ui_in),
        .uo_out               (uo_out),
        .o_audio              (o_audio),
        .o_audio_select       (o_audio_select),
        .i_addr               (i_addr),
        .i_data_in            (i_data_in),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .i_data_read_complete (i_data_read_complete)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic addr_t func_sel_addr(input int pin);
        return GPIO_BASE + addr_t'(FUNC_SEL_BASE) + addr_t'(pin * 4);
    endfunction

    function automatic void add_step(input op_t op, input addr_t addr, input data_t data,
                                     input pin_t ui, input data_t exp, input string name);
        steps.push_back('{op, addr, data, ui, exp, name});
    endfunction

    function automatic void build_table();
        pin_t       gpio_val;
        pin_t       ui_val;
        pin_t       ui_hold;
        logic [7:0] duty;
        int         pwm_pin;
        rng      = xorshift(rng);
        gpio_val = rng[7:0];
        ui_val   = rng[15:8];
        duty     = (rng[23:16] == 8'd0) ? 8'd77 : rng[23:16]; // Zero duty would prove little
        pwm_pin  = int'(rng[26:24]);
        rng      = xorshift(rng);
        ui_hold  = rng[7:0];
        add_step(OP_PINS, '0, '0, '0, '0, "uo_out after reset");
        add_step(OP_ASEL, '0, '0, '0, '0, "audio select after reset");
        for (int p = 0; p < 8; p++) begin
            add_step(OP_RD, func_sel_addr(p), '0, '0, data_t'(FUNC_GPIO),
                     $sformatf("func_sel %0d after reset", p));
        end
        add_step(OP_WR, GPIO_BASE + addr_t'(GPIO_OUT_OFS), data_t'(gpio_val), '0, '0, "gpio out");
        add_step(OP_PINS, '0, '0, '0, data_t'(gpio_val), "gpio out on pins");
        add_step(OP_RD, GPIO_BASE + addr_t'(GPIO_OUT_OFS), '0, '0, data_t'(gpio_val),
                 "gpio out readback");
        add_step(OP_RD, GPIO_BASE + addr_t'(GPIO_IN_OFS), '0, ui_val, data_t'(ui_val), "gpio in");
        add_step(OP_HOLD, GPIO_BASE + addr_t'(GPIO_IN_OFS), '0, ui_hold, data_t'(ui_hold),
                 "gpio in held");
        add_step(OP_RD, 11'h080, '0, '0, '0, "unmapped user slot");
        add_step(OP_RD, 11'h450, '0, '0, '0, "unmapped simple slot");
        add_step(OP_RD, 11'h7c0, '0, '0, '0, "unmapped upper user slot");
        add_step(OP_WR, func_sel_addr(pwm_pin), data_t'(FUNC_PWM), '0, '0, "pwm pin select");
        add_step(OP_RD, func_sel_addr(pwm_pin), '0, '0, data_t'(FUNC_PWM), "pwm pin readback");
        add_step(OP_WR, PWM_BASE, data_t'(duty), '0, '0, "pwm duty");
        add_step(OP_RD, PWM_BASE, '0, '0, data_t'(duty), "pwm duty readback");
        add_step(OP_WR, GPIO_BASE + addr_t'(GPIO_AUDIO_OFS), data_t'({1'b1, AUDIO_SRC_PWM}),
                 '0, '0, "audio select on");
        add_step(OP_RD, GPIO_BASE + addr_t'(GPIO_AUDIO_OFS), '0, '0,
                 data_t'({1'b1, AUDIO_SRC_PWM}), "audio select readback");
        add_step(OP_ASEL, '0, '0, '0, 32'd1, "audio select pin high");
        add_step(OP_PWM, '0, data_t'(pwm_pin), gpio_val, data_t'(duty), "pwm window");
        add_step(OP_WR, GPIO_BASE + addr_t'(GPIO_AUDIO_OFS), data_t'(AUDIO_SRC_PWM),
                 '0, '0, "audio select off");
        add_step(OP_ASEL, '0, '0, '0, '0, "audio select pin low");
    endfunction

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input data_t exp, input data_t act);
        $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        stop_run();
    endtask

    task automatic report_failure(input string what);
        $display("Error: %s", what);
        stop_run();
    endtask

    task automatic do_write(input step_t s);
        i_addr         = s.addr;
        i_data_in      = s.data;
        ui_in          = s.ui;
        i_data_write_n = ACC_WORD;
        #2;
        assert (o_data_ready) else report_failure({s.name, ": no ready during the write"});
        @(negedge clk);
        i_data_write_n = ACC_NONE;
    endtask

    task automatic do_read(input step_t s, input int stall);
        int waited;
        waited = 0;
        i_addr        = s.addr;
        ui_in         = s.ui;
        i_data_read_n = ACC_WORD;
        #1;
        // Ready must wait for the clock edge that samples the request
        assert (!o_data_ready)
            else report_failure({s.name, ": ready high before the request was sampled"});
        do begin
            @(negedge clk);
            waited++;
        end while (!o_data_ready && waited < READ_LIMIT);
        assert (o_data_ready) else report_failure({s.name, ": the DUT never raised ready"});
        assert (waited == 1)
            else report_mismatch({s.name, " ready latency"}, 32'd1, data_t'(waited));
        assert (o_data_out == s.exp) else report_mismatch(s.name, s.exp, o_data_out);
        // Core stalls while the pins keep moving
        for (int c = 0; c < stall; c++) begin
            ui_in = ~s.ui ^ pin_t'(c);
            @(negedge clk);
            assert (o_data_out == s.exp)
                else report_mismatch({s.name, " during stall"}, s.exp, o_data_out);
        end
        i_data_read_n        = ACC_NONE;
        i_data_read_complete = 1'b1;
        @(negedge clk);
        i_data_read_complete = 1'b0;
    endtask

    task automatic count_pwm(input step_t s);
        int   pin;
        int   pin_high;
        int   audio_high;
        pin_t mask;
        pin        = int'(s.data[2:0]);
        mask       = 8'd1 << pin;
        pin_high   = 0;
        audio_high = 0;
        for (int c = 0; c < 256; c++) begin // One full counter period
            @(negedge clk);
            if (uo_out[pin]) pin_high++;
            if (o_audio) audio_high++;
            assert ((uo_out & ~mask) == (s.ui & ~mask))
                else report_mismatch({s.name, " other pins"}, data_t'(s.ui & ~mask),
                                     data_t'(uo_out & ~mask));
        end
        assert (data_t'(pin_high) == s.exp)
            else report_mismatch({s.name, " pin high cycles"}, s.exp, data_t'(pin_high));
        assert (data_t'(audio_high) == s.exp)
            else report_mismatch({s.name, " audio high cycles"}, s.exp, data_t'(audio_high));
    endtask

    // Watchdog sized from the table once it exists
    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        report_failure("watchdog expired before the tests finished");
    end

    initial begin
        step_t s;
        int    pwm_windows;
        rst_n                = 1'b0;
        ui_in                = '0;
        i_addr               = '0;
        i_data_in            = '0;
        i_data_write_n       = ACC_NONE;
        i_data_read_n        = ACC_NONE;
        i_data_read_complete = 1'b0;
        rng                  = 32'hc16c;
        pwm_windows          = 0;
        build_table();
        foreach (steps[k]) begin
            if (steps[k].op == OP_PWM) pwm_windows++;
        end
        limit_cycles = 32 + steps.size() * (READ_LIMIT + 8) + pwm_windows * 256;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        foreach (steps[k]) begin
            s = steps[k];
            case (s.op)
                OP_WR:   do_write(s);
                OP_RD:   do_read(s, 0);
                OP_HOLD: do_read(s, 4);
                OP_PINS: assert (uo_out == s.exp[7:0])
                             else report_mismatch(s.name, s.exp, data_t'(uo_out));
                OP_ASEL: assert (o_audio_select == s.exp[0])
                             else report_mismatch(s.name, s.exp, data_t'(o_audio_select));
                default: count_pwm(s);
            endcase
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* periph_props.sv */
// Concurrent checks on the read response handshake, bound into every read_response instance
`timescale 1ns/1ps
`default_nettype none

module periph_props (
    input  wire                 clk,
    input  wire                 rst_n,
    input  periph_pkg::access_t i_data_read_n,
    input  periph_pkg::access_t i_data_write_n,
    input  wire                 hold,
    input  periph_pkg::data_t   data_q,
    input  wire                 o_data_ready
);
    import periph_pkg::*;

    logic read_req;
    logic write_now;

    assign read_req  = (i_data_read_n != ACC_NONE);
    assign write_now = (i_data_write_n != ACC_NONE);

    // Ready only follows a request from the cycle before, or a write right now
    ready_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
        o_data_ready |-> ($past(read_req) || write_now))
        else $error("Ready seen without a read request or a write");

    held_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        $past(hold) |-> $stable(data_q))
        else $error("Read data changed while held");

    ready_low_after_reset: assert property (@(posedge clk)
        !rst_n |=> (!o_data_ready || write_now))
        else $error("Ready high in the cycle after reset");

endmodule

bind read_response periph_props periph_props_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_data_read_n  (i_data_read_n),
    .i_data_write_n (i_data_write_n),
    .hold           (hold),
    .data_q         (data_q),
    .o_data_ready   (o_data_ready)
);

`default_nettype wire

/* periph_top.sv */
// Top level of the peripheral block with plain ports toward the core and the pins
`timescale 1ns/1ps
`default_nettype none

module periph_top (
    input  wire                 clk,
    input  wire                 rst_n,
    input  periph_pkg::pin_t    ui_in,
    output periph_pkg::pin_t    uo_out,
    output logic                o_audio,
    output logic                o_audio_select,
    input  periph_pkg::addr_t   i_addr,
    input  periph_pkg::data_t   i_data_in,
    input  periph_pkg::access_t i_data_write_n,
    input  periph_pkg::access_t i_data_read_n,
    output periph_pkg::data_t   o_data_out,
    output logic                o_data_ready,
    input  wire                 i_data_read_complete
);
    import periph_pkg::*;

    data_t     read_data;
    pin_t      gpio_out;
    pin_t      pwm_out;
    func_sel_t func_sel [8];
    logic [3:0] audio_sel;

    periph_bus_if gpio_bus ();
    periph_bus_if pwm_bus ();

    periph_decode periph_decode_inst (
        .i_addr         (i_addr),
        .i_data_in      (i_data_in),
        .i_data_write_n (i_data_write_n),
        .gpio_bus       (gpio_bus.decoder),
        .pwm_bus        (pwm_bus.decoder),
        .o_read_data    (read_data)
    );

    read_response read_response_inst (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_read_data          (read_data),
        .i_data_read_n        (i_data_read_n),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

    gpio_regs gpio_regs_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (gpio_bus.peripheral),
        .i_ui_in     (ui_in),
        .o_gpio_out  (gpio_out),
        .o_func_sel  (func_sel),
        .o_audio_sel (audio_sel)
    );

    pwm_byte pwm_byte_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (pwm_bus.peripheral),
        .o_pwm_out (pwm_out)
    );

    pin_mux pin_mux_inst (
        .clk         (clk),
        .i_gpio_out  (gpio_out),
        .i_pwm_out   (pwm_out),
        .i_func_sel  (func_sel),
        .i_audio_sel (audio_sel),
        .o_uo_out    (uo_out),
        .o_audio     (o_audio)
    );

    assign o_audio_select = audio_sel[3]; // Routes audio onto its pin

endmodule

`default_nettype wire

/* pin_mux.sv */
// Output pin multiplexer by function select, plus the registered audio output
`timescale 1ns/1ps
`default_nettype none

module pin_mux (
    input  wire                   clk,
    input  periph_pkg::pin_t      i_gpio_out,
    input  periph_pkg::pin_t      i_pwm_out,
    input  periph_pkg::func_sel_t i_func_sel [8],
    input  wire [3:0]             i_audio_sel,
    output periph_pkg::pin_t      o_uo_out,
    output logic                  o_audio
);
    import periph_pkg::*;

    // Each pin picks its own bit from the named source
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            case (i_func_sel[i])
                FUNC_GPIO: o_uo_out[i] = i_gpio_out[i];
                FUNC_PWM:  o_uo_out[i] = i_pwm_out[i];
                default:   o_uo_out[i] = 1'b0; // Peripheral not present
            endcase
        end
    end

    // Bit 3 of the select only routes the pin, handled at the top
    always_ff @(posedge clk) begin
        if (i_audio_sel[2:0] == AUDIO_SRC_PWM)
            o_audio <= i_pwm_out[0];
        else
            o_audio <= 1'b0;
    end

endmodule

`default_nettype wire

/* pwm_byte.sv */
// Byte-access PWM peripheral; all eight outputs are high while the counter is below the duty
`timescale 1ns/1ps
`default_nettype none

module pwm_byte (
    input  wire              clk,
    input  wire              rst_n,
    periph_bus_if.peripheral bus,
    output periph_pkg::pin_t o_pwm_out
);
    import periph_pkg::*;

    logic [7:0] count;
    logic [7:0] duty;
    logic       duty_hit;

    assign duty_hit = (bus.offset[3:0] == PWM_DUTY_OFS);

    // Free-running, wraps after 256 cycles
    always_ff @(posedge clk) begin
        if (!rst_n)
            count <= '0;
        else
            count <= count + 8'd1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            duty <= '0;  // Output stays low
        end else if (bus.sel && bus.write && duty_hit) begin
            duty <= bus.wdata[7:0];
        end
    end

    // Duty of N gives N high cycles per period
    assign o_pwm_out = {8{count < duty}};

    assign bus.rdata = duty_hit ? data_t'(duty) : '0;

endmodule

`default_nettype wire

/* gpio_regs.sv */
// GPIO register block: output register, input readback, pin function selects and audio select
`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
    input  wire                   clk,
    input  wire                   rst_n,
    periph_bus_if.peripheral      bus,
    input  periph_pkg::pin_t      i_ui_in,
    output periph_pkg::pin_t      o_gpio_out,
    output periph_pkg::func_sel_t o_func_sel [8],
    output logic [3:0]            o_audio_sel
);
    import periph_pkg::*;

    logic wr_en;
    logic func_hit;

    assign wr_en    = bus.sel && bus.write;
    assign func_hit = (bus.offset & FUNC_SEL_MASK) == FUNC_SEL_BASE; // Pin in bits 4:2

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_gpio_out <= '0;
        end else if (wr_en && bus.offset == GPIO_OUT_OFS) begin
            o_gpio_out <= bus.wdata[7:0];
        end
    end

    // All pins come up as GPIO
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                o_func_sel[i] <= FUNC_GPIO;
            end
        end else if (wr_en && func_hit) begin
            o_func_sel[bus.offset[4:2]] <= bus.wdata[5:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_audio_sel <= '0;  // Audio pin not selected
        end else if (wr_en && bus.offset == GPIO_AUDIO_OFS) begin
            o_audio_sel <= bus.wdata[3:0];
        end
    end

    // Readback
    always_comb begin
        if (bus.offset == GPIO_OUT_OFS)
            bus.rdata = data_t'(o_gpio_out);
        else if (bus.offset == GPIO_IN_OFS)
            bus.rdata = data_t'(i_ui_in);
        else if (bus.offset == GPIO_AUDIO_OFS)
            bus.rdata = data_t'(o_audio_sel);
        else if (func_hit)
            bus.rdata = data_t'(o_func_sel[bus.offset[4:2]]);
        else
            bus.rdata = '0;
    end

endmodule

`default_nettype wire

/* read_response.sv */
// Registered read response that holds the data until the core completes the read
`timescale 1ns/1ps
`default_nettype none

module read_response (
    input  wire                 clk,
    input  wire                 rst_n,
    input  periph_pkg::data_t   i_read_data,
    input  periph_pkg::access_t i_data_read_n,
    input  periph_pkg::access_t i_data_write_n,
    input  wire                 i_data_read_complete,
    output periph_pkg::data_t   o_data_out,
    output logic                o_data_ready
);
    import periph_pkg::*;

    logic  read_req;
    logic  hold;
    logic  ready_q;
    data_t data_q;

    assign read_req = (i_data_read_n != ACC_NONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_data_read_complete) hold <= 1'b0;
            if (!hold && read_req) hold <= 1'b1; // First cycle of a read
            ready_q <= read_req;
        end
    end

    // Capture once per read, then keep it through any stall
    always_ff @(posedge clk) begin
        if (!hold && read_req) data_q <= i_read_data;
    end

    assign o_data_out   = data_q;
    assign o_data_ready = ready_q || (i_data_write_n != ACC_NONE); // Writes finish at once

endmodule

`default_nettype wire

/* periph_decode.sv */
// Address decoder that selects one peripheral and returns its read data to the core
`timescale 1ns/1ps
`default_nettype none

module periph_decode (
    input  periph_pkg::addr_t   i_addr,
    input  periph_pkg::data_t   i_data_in,
    input  periph_pkg::access_t i_data_write_n,
    periph_bus_if.decoder       gpio_bus,
    periph_bus_if.decoder       pwm_bus,
    output periph_pkg::data_t   o_read_data
);
    import periph_pkg::*;

    logic       is_simple;
    logic [3:0] simple_slot;
    logic [4:0] user_slot;
    logic       wr;

    always_comb begin
        is_simple   = (i_addr[10:9] == SIMPLE_REGION);
        simple_slot = i_addr[7:4]; // 16 byte slots
        // Upper user slots skip the simple region
        if (i_addr[10])
            user_slot = {i_addr[10], 1'b0, i_addr[8:6]};
        else
            user_slot = {1'b0, i_addr[9:6]};
    end

    assign wr = (i_data_write_n != ACC_NONE);

    assign gpio_bus.sel    = !is_simple && (user_slot == USER_GPIO_SLOT);
    assign gpio_bus.write  = wr;
    assign gpio_bus.offset = i_addr[5:0];
    assign gpio_bus.wdata  = i_data_in;

    assign pwm_bus.sel    = is_simple && (simple_slot == SIMPLE_PWM_SLOT);
    assign pwm_bus.write  = wr;
    assign pwm_bus.offset = i_addr[5:0]; // Byte peripheral looks at 3:0 only
    assign pwm_bus.wdata  = i_data_in;

    // At most one select is high, so a priority chain is enough
    always_comb begin
        if (gpio_bus.sel)
            o_read_data = gpio_bus.rdata;
        else if (pwm_bus.sel)
            o_read_data = pwm_bus.rdata;
        else
            o_read_data = '0; // Unmapped slot
    end

endmodule

`default_nettype wire

/* periph_bus_if.sv */
// Bus access from the address decoder to a single peripheral, one instance per peripheral
`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if;
    import periph_pkg::*;

    logic    sel;    // Address hits this peripheral
    logic    write;  // Core writes this cycle
    offset_t offset;
    data_t   wdata;
    data_t   rdata;  // Zero-extended for byte peripherals

    modport decoder (
        output sel, write, offset, wdata,
        input  rdata
    );

    modport peripheral (
        input  sel, write, offset, wdata,
        output rdata
    );

endinterface

`default_nettype wire

/* periph_pkg.sv */
// Shared types, address map and register offsets, imported by every peripheral block module
`default_nettype none

package periph_pkg;

    typedef logic [10:0] addr_t;     // Core address
    typedef logic [31:0] data_t;     // Bus data
    typedef logic [5:0]  offset_t;   // Register offset inside a full slot
    typedef logic [7:0]  pin_t;      // One bit per output pin
    typedef logic [5:0]  func_sel_t; // Bit 4 set: simple slot in 3:0, else user slot {5, 3:0}
    typedef logic [1:0]  access_t;   // Access size code

    // Access codes from the core
    localparam access_t ACC_BYTE = 2'd0;
    localparam access_t ACC_HALF = 2'd1;
    localparam access_t ACC_WORD = 2'd2;
    localparam access_t ACC_NONE = 2'd3;

    // Address map
    localparam logic [1:0] SIMPLE_REGION   = 2'd2; // addr[10:9] of the byte peripherals
    localparam logic [4:0] USER_GPIO_SLOT  = 5'd1;
    localparam logic [3:0] SIMPLE_PWM_SLOT = 4'd4;

    // Pin function codes
    localparam func_sel_t FUNC_GPIO = 6'h01;
    localparam func_sel_t FUNC_PWM  = 6'h14;

    // GPIO register offsets
    localparam offset_t GPIO_OUT_OFS   = 6'h00;
    localparam offset_t GPIO_IN_OFS    = 6'h04;
    localparam offset_t GPIO_AUDIO_OFS = 6'h10;
    localparam offset_t FUNC_SEL_BASE  = 6'h20;
    localparam offset_t FUNC_SEL_MASK  = 6'h23; // Bits that must match FUNC_SEL_BASE

    // Audio source code that picks the PWM
    localparam logic [2:0] AUDIO_SRC_PWM = 3'd2;

    // PWM register offset in its byte slot
    localparam logic [3:0] PWM_DUTY_OFS = 4'd0;

endpackage

`default_nettype wire
